// ==== ex_unit_macros.svh ====
`ifndef EX_UNIT_MACROS_SVH
`define EX_UNIT_MACROS_SVH

`define XLEN 32 // Data word width.

// Major opcodes in instr[6:0].
`define OPC_OP     7'b0110011
`define OPC_OP_IMM 7'b0010011
`define OPC_BRANCH 7'b1100011
`define OPC_JALR   7'b1100111
`define OPC_AUIPC  7'b0010111

`define F3_BEQ  3'b000
`define F3_BNE  3'b001

// ALU funct3 codes shared by OP and OP_IMM.
`define F3_ADD  3'b000
`define F3_SLL  3'b001
`define F3_SLT  3'b010
`define F3_SLTU 3'b011
`define F3_XOR  3'b100
`define F3_SR   3'b101 // funct7[5] picks arithmetic.
`define F3_OR   3'b110
`define F3_AND  3'b111

`endif

// ==== ex_unit_pkg.sv ====
package ex_unit_pkg;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm11_0;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		logic [6:0] opcode;
	} b_fmt_t;

	// One instruction word read in three formats.
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		b_fmt_t b;
	} instr_u;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_xor,
		alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra
	} alu_op_e;

	typedef enum logic [1:0] {
		fwd_reg = 2'd0, // Register file value.
		fwd_ex  = 2'd1, // EX hazard value.
		fwd_mem = 2'd2  // MEM hazard value.
	} fwd_sel_e;

endpackage

// ==== ex_alu.sv ====
`timescale 1ns/10ps
`include "ex_unit_macros.svh"

module ex_alu import ex_unit_pkg::*; (
	input  logic [`XLEN-1:0] a,
	input  logic [`XLEN-1:0] b,
	input  alu_op_e          op,
	output logic [`XLEN-1:0] y,
	output logic             zf,
	output logic             cf,
	output logic             eq
);

	localparam int SHW = $clog2(`XLEN);

	logic [`XLEN:0]   sum;
	logic [`XLEN-1:0] b_in;
	logic [SHW-1:0]   sh;

	assign b_in = (op == alu_sub) ? ~b : b;
	assign sum  = {1'b0, a} + {1'b0, b_in} + {{`XLEN{1'b0}}, (op == alu_sub)};
	assign sh   = b[SHW-1:0];

	always_comb begin
		case (op)
			alu_add,
			alu_sub:  y = sum[`XLEN-1:0];
			alu_and:  y = a & b;
			alu_or:   y = a | b;
			alu_xor:  y = a ^ b;
			alu_slt:  y = {{(`XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
			alu_sltu: y = {{(`XLEN-1){1'b0}}, (a < b)};
			alu_sll:  y = a << sh;
			alu_srl:  y = a >> sh;
			alu_sra:  y = $unsigned($signed(a) >>> sh);
			default:  y = sum[`XLEN-1:0];
		endcase
	end

	assign zf = (y == '0);
	assign cf = sum[`XLEN]; // No-borrow on subtract.

	// Bitwise difference folded to one bit.
	assign eq = ~|(a ^ b);

endmodule

// ==== ex_decode.sv ====
`timescale 1ns/10ps
`include "ex_unit_macros.svh"

module ex_decode import ex_unit_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic              in_valid,
	input  instr_u            instr,
	input  logic [`XLEN-1:0]  pc,
	input  logic [`XLEN-1:0]  rs1_val,
	input  logic [`XLEN-1:0]  rs2_val,
	input  logic [`XLEN-1:0]  ex_haz,
	input  logic [`XLEN-1:0]  mem_haz,
	input  fwd_sel_e          fwd_a,
	input  fwd_sel_e          fwd_b,
	input  logic              predicted,
	input  logic              squash,
	output logic              d_valid,
	output logic [`XLEN-1:0]  d_pc,
	output alu_op_e           d_op,
	output logic [`XLEN-1:0]  d_imm,
	output logic              d_use_imm,
	output logic              d_use_pc,
	output logic              d_is_beq,
	output logic              d_is_bne,
	output logic              d_is_jalr,
	output logic [4:0]        d_rd,
	output logic              d_reg_write,
	output logic              d_predicted,
	output logic [`XLEN-1:0]  d_rs1,
	output logic [`XLEN-1:0]  d_rs2,
	output logic [`XLEN-1:0]  d_ex_haz,
	output logic [`XLEN-1:0]  d_mem_haz,
	output fwd_sel_e          d_fwd_a,
	output fwd_sel_e          d_fwd_b
);

	alu_op_e          op_c;
	logic [`XLEN-1:0] imm_c;
	logic             use_imm_c, use_pc_c, is_beq_c, is_bne_c, is_jalr_c, reg_write_c;
	logic [2:0]       f3;

	function automatic alu_op_e f3_to_op(input logic [2:0] fn3, input logic alt, input logic sub_ok);
		case (fn3)
			`F3_ADD:  f3_to_op = (alt && sub_ok) ? alu_sub : alu_add;
			`F3_SLL:  f3_to_op = alu_sll;
			`F3_SLT:  f3_to_op = alu_slt;
			`F3_SLTU: f3_to_op = alu_sltu;
			`F3_XOR:  f3_to_op = alu_xor;
			`F3_SR:   f3_to_op = alt ? alu_sra : alu_srl;
			`F3_OR:   f3_to_op = alu_or;
			default:  f3_to_op = alu_and;
		endcase
	endfunction

	assign f3 = instr.r.funct3;

	always_comb begin
		op_c        = alu_add;
		imm_c       = '0;
		use_imm_c   = 1'b0;
		use_pc_c    = 1'b0;
		is_beq_c    = 1'b0;
		is_bne_c    = 1'b0;
		is_jalr_c   = 1'b0;
		reg_write_c = 1'b0;
		case (instr.r.opcode)
			`OPC_OP: begin
				op_c        = f3_to_op(f3, instr.r.funct7[5], 1'b1);
				reg_write_c = 1'b1;
			end
			`OPC_OP_IMM: begin
				op_c        = f3_to_op(f3, instr.i.imm11_0[10], 1'b0); // No subi.
				imm_c       = {{(`XLEN-12){instr.i.imm11_0[11]}}, instr.i.imm11_0};
				use_imm_c   = 1'b1;
				reg_write_c = 1'b1;
			end
			`OPC_BRANCH: begin
				imm_c    = {{(`XLEN-13){instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
				            instr.b.imm10_5, instr.b.imm4_1, 1'b0};
				is_beq_c = (instr.b.funct3 == `F3_BEQ);
				is_bne_c = (instr.b.funct3 == `F3_BNE);
			end
			`OPC_JALR: begin
				imm_c       = {{(`XLEN-12){instr.i.imm11_0[11]}}, instr.i.imm11_0};
				use_imm_c   = 1'b1;
				use_pc_c    = 1'b1;
				is_jalr_c   = 1'b1;
				reg_write_c = 1'b1;
			end
			`OPC_AUIPC: begin
				imm_c       = {instr.r.funct7, instr.r.rs2, instr.r.rs1, instr.r.funct3, 12'b0};
				use_imm_c   = 1'b1;
				use_pc_c    = 1'b1;
				reg_write_c = 1'b1;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			d_valid <= 1'b0;
		else
			d_valid <= in_valid && !squash; // Drop the slot behind a redirect.
		d_pc        <= pc;
		d_op        <= op_c;
		d_imm       <= imm_c;
		d_use_imm   <= use_imm_c;
		d_use_pc    <= use_pc_c;
		d_is_beq    <= is_beq_c;
		d_is_bne    <= is_bne_c;
		d_is_jalr   <= is_jalr_c;
		d_rd        <= instr.r.rd;
		d_reg_write <= reg_write_c;
		d_predicted <= predicted;
		d_rs1       <= rs1_val;
		d_rs2       <= rs2_val;
		d_ex_haz    <= ex_haz;
		d_mem_haz   <= mem_haz;
		d_fwd_a     <= fwd_a;
		d_fwd_b     <= fwd_b;
	end

endmodule

// ==== ex_stage.sv ====
`timescale 1ns/10ps
`include "ex_unit_macros.svh"

module ex_stage import ex_unit_pkg::*; (
	input  logic              d_valid,
	input  logic [`XLEN-1:0]  d_pc,
	input  alu_op_e           d_op,
	input  logic [`XLEN-1:0]  d_imm,
	input  logic              d_use_imm,
	input  logic              d_use_pc,
	input  logic              d_is_beq,
	input  logic              d_is_bne,
	input  logic              d_is_jalr,
	input  logic [4:0]        d_rd,
	input  logic              d_reg_write,
	input  logic              d_predicted,
	input  logic [`XLEN-1:0]  d_rs1,
	input  logic [`XLEN-1:0]  d_rs2,
	input  logic [`XLEN-1:0]  d_ex_haz,
	input  logic [`XLEN-1:0]  d_mem_haz,
	input  fwd_sel_e          d_fwd_a,
	input  fwd_sel_e          d_fwd_b,
	output logic              x_valid,
	output logic [`XLEN-1:0]  x_alu_out,
	output logic [`XLEN-1:0]  x_store_data,
	output logic [4:0]        x_rd,
	output logic              x_reg_write,
	output logic              x_redirect,
	output logic [`XLEN-1:0]  x_target
);

	logic [`XLEN-1:0] rs1_fwd, rs2_fwd, op_a, op_b, alu_y, pc_plus4;
	logic [`XLEN-1:0] tgt_a, tgt_b, tgt_sum;
	logic             eq, taken;

	function automatic logic [`XLEN-1:0] fwd_pick(input fwd_sel_e sel,
		input logic [`XLEN-1:0] reg_v, input logic [`XLEN-1:0] ex_v,
		input logic [`XLEN-1:0] mem_v);
		case (sel)
			fwd_ex:  fwd_pick = ex_v;
			fwd_mem: fwd_pick = mem_v;
			default: fwd_pick = reg_v;
		endcase
	endfunction

	assign rs1_fwd  = fwd_pick(d_fwd_a, d_rs1, d_ex_haz, d_mem_haz);
	assign rs2_fwd  = fwd_pick(d_fwd_b, d_rs2, d_ex_haz, d_mem_haz);
	assign op_a     = d_use_pc ? d_pc : rs1_fwd;
	assign op_b     = d_use_imm ? d_imm : rs2_fwd;
	assign pc_plus4 = d_pc + `XLEN'd4;

	ex_alu u_alu (.a(op_a), .b(op_b), .op(d_op), .y(alu_y), .zf(), .cf(), .eq(eq));

	assign taken = (d_is_beq && eq) || (d_is_bne && !eq);

	// Redirect address. Jump register base or branch offset from pc.
	assign tgt_a = d_is_jalr ? rs1_fwd : d_pc;
	assign tgt_b = (d_is_jalr || taken) ? d_imm : `XLEN'd4;

	ex_alu u_tgt (.a(tgt_a), .b(tgt_b), .op(alu_add), .y(tgt_sum), .zf(), .cf(), .eq());

	assign x_valid      = d_valid;
	assign x_alu_out    = d_is_jalr ? pc_plus4 : alu_y; // Link address.
	assign x_store_data = rs2_fwd;
	assign x_rd         = d_rd;
	assign x_reg_write  = d_reg_write;
	assign x_redirect   = d_is_jalr || ((d_is_beq || d_is_bne) && (taken != d_predicted));
	assign x_target     = d_is_jalr ? {tgt_sum[`XLEN-1:1], 1'b0} : tgt_sum;

endmodule

// ==== ex_result.sv ====
`timescale 1ns/10ps
`include "ex_unit_macros.svh"

module ex_result (
	input  logic              clk,
	input  logic              rst,
	input  logic              x_valid,
	input  logic [`XLEN-1:0]  x_alu_out,
	input  logic [`XLEN-1:0]  x_store_data,
	input  logic [4:0]        x_rd,
	input  logic              x_reg_write,
	input  logic              x_redirect,
	input  logic [`XLEN-1:0]  x_target,
	output logic              out_valid,
	output logic [`XLEN-1:0]  alu_out,
	output logic [`XLEN-1:0]  store_data,
	output logic [4:0]        rd,
	output logic              reg_write,
	output logic              redirect,
	output logic [`XLEN-1:0]  target,
	output logic              squash
);

	// Redirect of the valid result being captured at this edge.
	assign squash = x_valid && x_redirect;

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
			reg_write <= 1'b0;
			redirect  <= 1'b0;
		end else begin
			out_valid <= x_valid;
			reg_write <= x_valid && x_reg_write && (x_rd != 5'd0); // x0 is never written.
			redirect  <= squash;
		end
		alu_out    <= x_alu_out;
		store_data <= x_store_data;
		rd         <= x_rd;
		target     <= x_target;
	end

endmodule

// ==== ex_unit.sv ====
`timescale 1ns/10ps
`include "ex_unit_macros.svh"

module ex_unit import ex_unit_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic              in_valid,
	input  instr_u            instr,
	input  logic [`XLEN-1:0]  pc,
	input  logic [`XLEN-1:0]  rs1_val,
	input  logic [`XLEN-1:0]  rs2_val,
	input  logic [`XLEN-1:0]  ex_haz,
	input  logic [`XLEN-1:0]  mem_haz,
	input  fwd_sel_e          fwd_a,
	input  fwd_sel_e          fwd_b,
	input  logic              predicted,
	output logic              out_valid,
	output logic [`XLEN-1:0]  alu_out,
	output logic [`XLEN-1:0]  store_data,
	output logic [4:0]        rd,
	output logic              reg_write,
	output logic              redirect,
	output logic [`XLEN-1:0]  target
);

	logic             d_valid, d_use_imm, d_use_pc, d_is_beq, d_is_bne, d_is_jalr;
	logic             d_reg_write, d_predicted;
	logic [`XLEN-1:0] d_pc, d_imm, d_rs1, d_rs2, d_ex_haz, d_mem_haz;
	logic [4:0]       d_rd;
	alu_op_e          d_op;
	fwd_sel_e         d_fwd_a, d_fwd_b;
	logic             x_valid, x_reg_write, x_redirect, squash;
	logic [`XLEN-1:0] x_alu_out, x_store_data, x_target;
	logic [4:0]       x_rd;

	ex_decode u_decode (.*);

	ex_stage u_stage (.*);

	ex_result u_result (.*);

endmodule

// ==== ex_unit_clk.sv ====
`timescale 1ns/10ps

module ex_unit_clk (
	output logic clk
);

	initial clk = 1'b0;

	always #10 clk = ~clk; // 20 ns period.

endmodule

// ==== ex_unit_sva.sv ====
`timescale 1ns/10ps

module ex_unit_sva (
	input logic       clk,
	input logic       rst,
	input logic       out_valid,
	input logic       reg_write,
	input logic       redirect,
	input logic [4:0] rd
);

	a_reset_quiet: assert property (@(posedge clk) rst |=> !out_valid && !reg_write && !redirect)
		else $error("Outputs active in the cycle after reset");

	a_redirect_valid: assert property (@(posedge clk) disable iff (rst) redirect |-> out_valid)
		else $error("Redirect raised without a valid result");

	a_no_x0_write: assert property (@(posedge clk) disable iff (rst) reg_write |-> rd != 5'd0)
		else $error("Register write enabled for x0");

	// Younger slot is squashed behind a redirect.
	a_squash_slot: assert property (@(posedge clk) disable iff (rst) redirect |=> !out_valid)
		else $error("Result appeared in the slot after a redirect");

endmodule

bind ex_unit ex_unit_sva u_sva (
	.clk(clk),
	.rst(rst),
	.out_valid(out_valid),
	.reg_write(reg_write),
	.redirect(redirect),
	.rd(rd)
);

// ==== ex_unit_tb.sv ====
`timescale 1ns/10ps
`include "ex_unit_macros.svh"

module ex_unit_tb import ex_unit_pkg::*; ();

	logic             clk, rst, in_valid, predicted;
	instr_u           instr;
	logic [`XLEN-1:0] pc, rs1_val, rs2_val, ex_haz, mem_haz;
	fwd_sel_e         fwd_a, fwd_b;
	logic             out_valid, reg_write, redirect;
	logic [`XLEN-1:0] alu_out, store_data, target;
	logic [4:0]       rd;

	logic [31:0]      seed = 32'hcb73_68a0;
	int               errors = 0;
	int               checks = 0;
	logic             q_v[$], q_rw[$], q_rdir[$], q_tchk[$]; // Expected results in issue order.
	logic [31:0]      q_alu[$], q_st[$], q_tgt[$];
	logic [4:0]       q_rd[$];

	ex_unit_clk u_clk (.clk(clk));

	ex_unit uut (.*);

	function automatic logic [31:0] rand32();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic fwd_sel_e fwd_from(input logic [1:0] k);
		case (k)
			2'd1:    return fwd_ex;
			2'd2:    return fwd_mem;
			default: return fwd_reg;
		endcase
	endfunction

	function automatic logic [31:0] fwd_value(input fwd_sel_e sel, input logic [31:0] r,
		input logic [31:0] e, input logic [31:0] m);
		case (sel)
			fwd_ex:  return e;
			fwd_mem: return m;
			default: return r;
		endcase
	endfunction

	// RV32 integer result; alt means sub or arithmetic shift.
	function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			`F3_ADD:  return alt ? a - b : a + b;
			`F3_SLL:  return a << b[4:0];
			`F3_SLT:  return {31'b0, $signed(a) < $signed(b)};
			`F3_SLTU: return {31'b0, a < b};
			`F3_XOR:  return a ^ b;
			`F3_SR:   return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
			`F3_OR:   return a | b;
			default:  return a & b;
		endcase
	endfunction

	function automatic logic pending();
		foreach (q_v[k])
			if (q_v[k])
				return 1'b1;
		return 1'b0;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expv,
		input logic [31:0] gotv);
		checks++;
		if (gotv !== expv) begin
			errors++;
			$display("Fail %s exp %h got %h", name, expv, gotv);
		end
	endtask

	task automatic issue_random(input logic allow);
		logic [31:0] r, r2, p, a, b, res, tgt;
		logic [11:0] imm12;
		logic [12:0] boff;
		logic [6:0]  f7;
		logic [2:0]  f3;
		logic [4:0]  rd_f, rs1_f, rs2_f;
		logic        taken, rdir, wr, tchk;
		int          cls;
		r = rand32();
		r2 = rand32();
		p = rand32();
		in_valid = allow && (r[2:0] != 3'd0);
		cls = int'(r[15:8]) % 5;
		rd_f = (r[18:16] == 3'd0) ? 5'd0 : r[23:19];
		rs1_f = r[28:24];
		rs2_f = r2[24:20];
		predicted = r[4];
		fwd_a = fwd_from(r[6:5]);
		fwd_b = fwd_from(r[9:8] ^ r[25:24]);
		pc = {p[31:2], 2'b00};
		rs1_val = rand32();
		rs2_val = rand32();
		ex_haz = rand32();
		mem_haz = rand32();
		if (cls == 2 && r[7]) begin
			a = fwd_value(fwd_a, rs1_val, ex_haz, mem_haz); // Force equal compare operands.
			case (fwd_b)
				fwd_ex:  ex_haz = a;
				fwd_mem: mem_haz = a;
				default: rs2_val = a;
			endcase
		end
		a = fwd_value(fwd_a, rs1_val, ex_haz, mem_haz);
		b = fwd_value(fwd_b, rs2_val, ex_haz, mem_haz);
		imm12 = r2[31:20];
		f3 = r2[14:12];
		wr = (rd_f != 5'd0);
		rdir = 1'b0;
		tchk = 1'b0;
		tgt = '0;
		case (cls)
			0: begin
				f7 = ((f3 == `F3_ADD || f3 == `F3_SR) && r2[30]) ? 7'h20 : 7'h00;
				instr = {f7, rs2_f, rs1_f, f3, rd_f, `OPC_OP};
				res = alu_model(f3, f7[5], a, b);
			end
			1: begin
				if (f3 == `F3_SLL)
					imm12[11:5] = 7'h00;
				if (f3 == `F3_SR)
					imm12[11:5] = {1'b0, r2[30], 5'b0};
				instr = {imm12, rs1_f, f3, rd_f, `OPC_OP_IMM};
				res = alu_model(f3, (f3 == `F3_SR) && imm12[10], a, {{20{imm12[11]}}, imm12});
			end
			2: begin
				f3 = {2'b00, r2[12]};
				boff = {imm12, 1'b0};
				instr = {boff[12], boff[10:5], rs2_f, rs1_f, f3,
				         boff[4:1], boff[11], `OPC_BRANCH};
				rd_f = {boff[4:1], boff[11]}; // B format puts offset bits in the rd field.
				taken = ((f3 == `F3_BEQ) == (a == b));
				res = a + b;
				rdir = (taken != predicted);
				tgt = taken ? pc + {{19{boff[12]}}, boff} : pc + 32'd4;
				wr = 1'b0;
				tchk = 1'b1;
			end
			3: begin
				instr = {imm12, rs1_f, 3'b000, rd_f, `OPC_JALR};
				res = pc + 32'd4;
				tgt = a + {{20{imm12[11]}}, imm12};
				tgt[0] = 1'b0;
				rdir = 1'b1;
				tchk = 1'b1;
			end
			default: begin
				instr = {r2[31:12], rd_f, `OPC_AUIPC};
				res = pc + {r2[31:12], 12'b0};
			end
		endcase
		q_v.push_back(in_valid);
		q_rw.push_back(in_valid && wr);
		q_rdir.push_back(in_valid && rdir);
		q_tchk.push_back(tchk);
		q_alu.push_back(res);
		q_st.push_back(b);
		q_tgt.push_back(tgt);
		q_rd.push_back(rd_f);
	endtask

	task automatic check_outputs();
		logic        v, rw, rdir, tchk;
		logic [31:0] alu_e, st_e, tgt_e;
		logic [4:0]  rd_e;
		v = q_v.pop_front();
		rw = q_rw.pop_front();
		rdir = q_rdir.pop_front();
		tchk = q_tchk.pop_front();
		alu_e = q_alu.pop_front();
		st_e = q_st.pop_front();
		tgt_e = q_tgt.pop_front();
		rd_e = q_rd.pop_front();
		check_value("out_valid", {31'b0, v}, {31'b0, out_valid});
		check_value("reg_write", {31'b0, rw}, {31'b0, reg_write});
		check_value("redirect", {31'b0, rdir}, {31'b0, redirect});
		if (v) begin
			check_value("alu_out", alu_e, alu_out);
			check_value("store_data", st_e, store_data);
			check_value("rd", {27'b0, rd_e}, {27'b0, rd});
			if (tchk)
				check_value("target", tgt_e, target);
		end
		if (rdir && q_v.size() > 0) begin
			q_v[0] = 1'b0; // Next slot never leaves decode.
			q_rw[0] = 1'b0;
			q_rdir[0] = 1'b0;
		end
	endtask

	initial begin
		int guard;
		rst = 1'b1;
		in_valid = 1'b0;
		instr = '0;
		pc = '0;
		rs1_val = '0;
		rs2_val = '0;
		ex_haz = '0;
		mem_haz = '0;
		fwd_a = fwd_reg;
		fwd_b = fwd_reg;
		predicted = 1'b0;
		for (int i = 0; i < 16; i++)
			@(negedge clk);
		rst = 1'b0;
		for (int i = 0; i < 600; i++) begin
			if (q_v.size() == 2)
				check_outputs();
			issue_random(i >= 4); // A few idle slots first.
			@(negedge clk);
		end
		guard = 0;
		while (pending() && guard < 8) begin
			check_outputs();
			issue_random(1'b0);
			@(negedge clk);
			guard++;
		end
		if (pending()) begin
			errors++;
			$display("Timed out waiting for the last results to leave the pipeline");
		end
		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== ex_unit.f ====
+incdir+.
ex_unit_pkg.sv
ex_alu.sv
ex_decode.sv
ex_stage.sv
ex_result.sv
ex_unit.sv
ex_unit_clk.sv
ex_unit_sva.sv
ex_unit_tb.sv

// ==== Makefile ====
SIM   = verilator
FLAGS = --binary --timing --assert -j 0
TOP   = ex_unit_tb
FLIST = ex_unit.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | awk '{ print } /^Test passed$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
